//--- build.f
src/odt_pkg.sv
src/odt_req_if.sv
src/odt_target_decode.sv
src/odt_pin_timer.sv
src/odt_output_stage.sv
src/odt_gen_top.sv
test/tb_odt_gen.sv

//--- test/tb_odt_gen.sv
// odt generator testbench checking each cycle against a window model over a table of config phases
`timescale 1ns/1ps

module tb_odt_gen;
    import odt_pkg::*;

    localparam int NUM_PHASES   = 8;
    localparam int MODEL_DEPTH  = 64;   // ring of future cycles longer than any delay plus window
    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_CYCLES = 44;   // lets every window close before the config moves

    typedef struct packed {
        logic [TYPE_WIDTH-1:0] mem_type;
        logic [LAT_WIDTH-1:0]  tcl;
        logic [LAT_WIDTH-1:0]  cwl;
        logic [AL_WIDTH-1:0]   al;
        logic [BL_WIDTH-1:0]   bl;
        logic                  regd;     // extra output register
        logic [MAP_WIDTH-1:0]  wr_map;
        logic [MAP_WIDTH-1:0]  rd_map;
        logic [7:0]            cmds;
        logic [7:0]            gap_min;  // idle clocks after each command
        logic [7:0]            gap_max;
    } phase_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [TYPE_WIDTH-1:0] cfg_type;
    logic [LAT_WIDTH-1:0]  cfg_tcl;
    logic [LAT_WIDTH-1:0]  cfg_cwl;
    logic [AL_WIDTH-1:0]   cfg_al;
    logic [BL_WIDTH-1:0]   cfg_bl;
    logic [MAP_WIDTH-1:0]  cfg_wr_map;
    logic [MAP_WIDTH-1:0]  cfg_rd_map;
    logic                  cfg_regd;
    logic                  do_write;
    logic                  do_read;
    logic [CHIP_COUNT-1:0] to_chip;
    logic [ODT_WIDTH-1:0]  afi_odt;

    bit [ODT_WIDTH-1:0] model [MODEL_DEPTH];   // expected afi_odt_o indexed by edge number
    int                 edge_num = 0;           // rising edges seen so far
    int                 cycle_limit;
    logic [31:0]        rng_state;

    odt_gen_top i_dut (
        .ctl_clk_i           (clk),
        .rst_n_i             (rst_n),
        .cfg_type_i          (cfg_type),
        .cfg_tcl_i           (cfg_tcl),
        .cfg_cwl_i           (cfg_cwl),
        .cfg_al_i            (cfg_al),
        .cfg_burst_length_i  (cfg_bl),
        .cfg_write_odt_map_i (cfg_wr_map),
        .cfg_read_odt_map_i  (cfg_rd_map),
        .cfg_output_regd_i   (cfg_regd),
        .do_write_i          (do_write),
        .do_read_i           (do_read),
        .to_chip_i           (to_chip),
        .afi_odt_o           (afi_odt)
    );

    initial
    begin
        forever
        begin
            #50 clk = ~clk;   // 100 ns period
        end
    end

    function automatic phase_t phase_row(input int idx);
        phase_t row;
        case (idx)
            // type tcl cwl al bl regd wr_map rd_map cmds gap_min gap_max
            0: row = '{3'd3, 4'd6, 4'd5, 3'd0, 5'd8, 1'b0, 16'h5a3c, 16'h96f1, 8'd12, 8'd0, 8'd3};
            1: row = '{3'd2, 4'd6, 4'd5, 3'd0, 5'd4, 1'b0, 16'h5a3c, 16'h96f1, 8'd8, 8'd12, 8'd14};
            2: row = '{3'd2, 4'd7, 4'd6, 3'd2, 5'd8, 1'b0, 16'hc381, 16'h1e74, 8'd8, 8'd16, 8'd18};
            3: row = '{3'd1, 4'd5, 4'd0, 3'd3, 5'd4, 1'b0, 16'h3c5a, 16'hf196, 8'd16, 8'd0, 8'd6};
            4: row = '{3'd1, 4'd6, 4'd0, 3'd1, 5'd8, 1'b1, 16'h8421, 16'h1248, 8'd16, 8'd12, 8'd14};
            5: row = '{3'd2, 4'd11, 4'd8, 3'd4, 5'd8, 1'b0, 16'ha5a5, 16'h5a5a, 8'd40, 8'd0, 8'd2};
            6: row = '{3'd2, 4'd5, 4'd5, 3'd0, 5'd4, 1'b1, 16'h6c93, 16'h39c6, 8'd40, 8'd0, 8'd4};
            7: row = '{3'd2, 4'd14, 4'd10, 3'd7, 5'd8, 1'b0, 16'hf00f, 16'h0ff0, 8'd60, 8'd0, 8'd8};
            default: row = '0;
        endcase
        return row;
    endfunction

    // sum of commands times slot length plus 64 per phase for setup and drain
    function automatic int run_limit();
        int     sum;
        phase_t row;
        sum = 0;
        for (int i = 0; i < NUM_PHASES; i++)
        begin
            row = phase_row(i);
            sum = sum + int'(row.cmds) * (int'(row.gap_max) + 1) + 64;
        end
        return sum;
    endfunction

    // lcg step with the upper bits giving a draw in 0..range-1
    function automatic int lcg_pick(input int range);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return int'(rng_state[30:16]) % range;
    endfunction

    // ddr2 writes at tcl+al-4 and reads at tcl+al-3, ddr3 writes at cwl+al-2 and reads at tcl+al-2
    function automatic int window_delay(input phase_t row, input bit is_write);
        int lat;
        if (row.mem_type == MEM_TYPE_DDR2)
        begin
            lat = int'(row.tcl) + int'(row.al) - (is_write ? 4 : 3);
        end
        else
        begin
            lat = (is_write ? int'(row.cwl) : int'(row.tcl)) + int'(row.al) - 2;
        end
        return lat;
    endfunction

    // strobe is sampled at edge t = edge_num + 2 and pins go high after edges t+d+1 .. t+d+w
    task automatic mark_window(input logic [ODT_WIDTH-1:0] mask, input int d, input int w,
                               input int regd);
        int idx;
        for (int k = 1; k <= w; k++)
        begin
            idx        = (edge_num + 2 + d + regd + k) % MODEL_DEPTH;
            model[idx] = model[idx] | mask;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Error: %s is %h, expected %h at edge %0d", name, actual, expected,
                     edge_num);
            $display("Testbench failed");
            $fatal(1, "output mismatch");
        end
    endtask

    // sample between rising edges where afi_odt_o is settled
    always @(negedge clk)
    begin
        edge_num = edge_num + 1;
        check_value("afi_odt_o", 32'(afi_odt), 32'(model[edge_num % MODEL_DEPTH]));
        model[edge_num % MODEL_DEPTH] = '0;   // slot reused MODEL_DEPTH edges later
        if (edge_num > cycle_limit)
        begin
            $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        phase_t               row;
        int                   wr_d;
        int                   rd_d;
        int                   win;
        int                   gap;
        int                   chip;
        int                   kind;    // 0 write, 1 read, 2 both in one cycle
        bit                   known;
        logic [ODT_WIDTH-1:0] mask;
        cycle_limit = run_limit();
        rng_state   = 32'h310e;
        rst_n       = 1'b0;
        cfg_type    = '0;
        cfg_tcl     = '0;
        cfg_cwl     = '0;
        cfg_al      = '0;
        cfg_bl      = '0;
        cfg_wr_map  = '0;
        cfg_rd_map  = '0;
        cfg_regd    = 1'b0;
        do_write    = 1'b0;
        do_read     = 1'b0;
        to_chip     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int ph = 0; ph < NUM_PHASES; ph++)
        begin
            row   = phase_row(ph);
            wr_d  = window_delay(row, 1'b1);
            rd_d  = window_delay(row, 1'b0);
            win   = int'(row.bl) / 2 + 2;
            known = (row.mem_type == MEM_TYPE_DDR2) || (row.mem_type == MEM_TYPE_DDR3);
            @(posedge clk);
            cfg_type   <= row.mem_type;
            cfg_tcl    <= row.tcl;
            cfg_cwl    <= row.cwl;
            cfg_al     <= row.al;
            cfg_bl     <= row.bl;
            cfg_wr_map <= row.wr_map;
            cfg_rd_map <= row.rd_map;
            cfg_regd   <= row.regd;
            for (int n = 0; n < int'(row.cmds); n++)
            begin
                if (n < 2 * CHIP_COUNT)
                begin
                    chip = n % CHIP_COUNT;   // sweep with a write to every chip and then a read
                    kind = n / CHIP_COUNT;
                end
                else
                begin
                    chip = lcg_pick(CHIP_COUNT);
                    kind = lcg_pick(3);
                end
                gap = int'(row.gap_min) + lcg_pick(int'(row.gap_max) - int'(row.gap_min) + 1);
                @(posedge clk);
                do_write <= (kind != 1);
                do_read  <= (kind != 0);
                to_chip  <= CHIP_COUNT'(1) << chip;
                if (known && kind != 1)
                begin
                    mask = row.wr_map[chip*ODT_WIDTH +: ODT_WIDTH];
                    mark_window(mask, wr_d, win, int'(row.regd));
                end
                if (known && kind != 0)
                begin
                    mask = row.rd_map[chip*ODT_WIDTH +: ODT_WIDTH];
                    mark_window(mask, rd_d, win, int'(row.regd));
                end
                repeat (gap)
                begin
                    @(posedge clk);
                    do_write <= 1'b0;
                    do_read  <= 1'b0;
                end
            end
            @(posedge clk);
            do_write <= 1'b0;
            do_read  <= 1'b0;
            repeat (DRAIN_CYCLES) @(posedge clk);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- src/odt_gen_top.sv
// odt generator top, decodes arbiter commands into timed odt windows on the afi
`timescale 1ns/1ps

module odt_gen_top (
    input  logic                           ctl_clk_i,
    input  logic                           rst_n_i,
    input  logic [odt_pkg::TYPE_WIDTH-1:0] cfg_type_i,
    input  logic [odt_pkg::LAT_WIDTH-1:0]  cfg_tcl_i,
    input  logic [odt_pkg::LAT_WIDTH-1:0]  cfg_cwl_i,
    input  logic [odt_pkg::AL_WIDTH-1:0]   cfg_al_i,
    input  logic [odt_pkg::BL_WIDTH-1:0]   cfg_burst_length_i,
    input  logic [odt_pkg::MAP_WIDTH-1:0]  cfg_write_odt_map_i,
    input  logic [odt_pkg::MAP_WIDTH-1:0]  cfg_read_odt_map_i,
    input  logic                           cfg_output_regd_i,
    input  logic                           do_write_i,
    input  logic                           do_read_i,
    input  logic [odt_pkg::CHIP_COUNT-1:0] to_chip_i,      // one-hot
    output logic [odt_pkg::ODT_WIDTH-1:0]  afi_odt_o
);
    import odt_pkg::*;

    logic [ODT_WIDTH-1:0] pin_win;   // raw window per pin, before the afi flops

    odt_req_if req_bus ();

    odt_target_decode i_decode (
        .cfg_type_i          (cfg_type_i),
        .cfg_tcl_i           (cfg_tcl_i),
        .cfg_cwl_i           (cfg_cwl_i),
        .cfg_al_i            (cfg_al_i),
        .cfg_burst_length_i  (cfg_burst_length_i),
        .cfg_write_odt_map_i (cfg_write_odt_map_i),
        .cfg_read_odt_map_i  (cfg_read_odt_map_i),
        .do_write_i          (do_write_i),
        .do_read_i           (do_read_i),
        .to_chip_i           (to_chip_i),
        .req                 (req_bus.source)
    );

    // one timer per odt pin, each picks its own strobe bit
    for (genvar p = 0; p < ODT_WIDTH; p++)
    begin : g_pin
        odt_pin_timer i_timer (
            .ctl_clk_i (ctl_clk_i),
            .rst_n_i   (rst_n_i),
            .req       (req_bus.sink),
            .pin_sel_i (PIN_SEL_WIDTH'(p)),
            .win_o     (pin_win[p])
        );
    end

    odt_output_stage i_out (
        .ctl_clk_i         (ctl_clk_i),
        .rst_n_i           (rst_n_i),
        .cfg_output_regd_i (cfg_output_regd_i),
        .win_i             (pin_win),
        .afi_odt_o         (afi_odt_o)
    );

endmodule

//--- src/odt_output_stage.sv
// odt output stage, registers the pin windows onto the afi with an optional extra clock
`timescale 1ns/1ps

module odt_output_stage (
    input  logic                          ctl_clk_i,
    input  logic                          rst_n_i,
    input  logic                          cfg_output_regd_i,  // add one clock of latency
    input  logic [odt_pkg::ODT_WIDTH-1:0] win_i,
    output logic [odt_pkg::ODT_WIDTH-1:0] afi_odt_o
);
    import odt_pkg::*;

    logic [ODT_WIDTH-1:0] odt_r1;   // first stage, always present
    logic [ODT_WIDTH-1:0] odt_r2;   // second stage for slow afi paths

    always_ff @(posedge ctl_clk_i)
    begin
        if (!rst_n_i)
        begin
            odt_r1 <= '0;
            odt_r2 <= '0;
        end
        else
        begin
            odt_r1 <= win_i;
            odt_r2 <= odt_r1;
        end
    end

    // config is static, so switching stages does not glitch in service
    assign afi_odt_o = cfg_output_regd_i ? odt_r2 : odt_r1;

endmodule

//--- src/odt_pin_timer.sv
// odt pin timer, delays the pin strobes and holds the termination window open
`timescale 1ns/1ps

module odt_pin_timer (
    input  logic                              ctl_clk_i,
    input  logic                              rst_n_i,
    odt_req_if.sink                           req,
    input  logic [odt_pkg::PIN_SEL_WIDTH-1:0] pin_sel_i,  // fixed per instance
    output logic                              win_o
);
    import odt_pkg::*;

    logic [DELAY_DEPTH-1:0] wr_line;     // bit k set means a write strobe k+1 clocks ago
    logic [DELAY_DEPTH-1:0] rd_line;     // same for reads
    logic [DELAY_WIDTH-1:0] wr_tap;
    logic [DELAY_WIDTH-1:0] rd_tap;
    logic                   wr_due;
    logic                   rd_due;
    logic [WIN_WIDTH-1:0]   win_cnt;     // clocks left in the open window
    logic [WIN_WIDTH-1:0]   cnt_dec;
    logic [WIN_WIDTH-1:0]   cnt_load;

    // strobe enters stage 0 at its own edge, so a delay of D reads stage D-1
    assign wr_tap = req.wr_delay - DELAY_WIDTH'(1);
    assign rd_tap = req.rd_delay - DELAY_WIDTH'(1);

    assign wr_due = wr_line[wr_tap];
    assign rd_due = rd_line[rd_tap];

    // count down to zero and stay there
    assign cnt_dec = (win_cnt != '0) ? win_cnt - WIN_WIDTH'(1) : '0;

    // a new window never cuts short one that is still open
    assign cnt_load = (cnt_dec > req.win_width) ? cnt_dec : req.win_width;

    always_ff @(posedge ctl_clk_i)
    begin
        if (!rst_n_i)
        begin
            wr_line <= '0;
            rd_line <= '0;
            win_cnt <= '0;
        end
        else
        begin
            // any number of commands can ride the lines at once
            wr_line <= {wr_line[DELAY_DEPTH-2:0], req.wr_hit[pin_sel_i]};
            rd_line <= {rd_line[DELAY_DEPTH-2:0], req.rd_hit[pin_sel_i]};

            if (wr_due || rd_due)
            begin
                win_cnt <= cnt_load;     // read and write landing together open one window
            end
            else
            begin
                win_cnt <= cnt_dec;
            end
        end
    end

    assign win_o = (win_cnt != '0);

endmodule

//--- src/odt_target_decode.sv
// odt target decode, picks the pin masks for the addressed chip and derives window timing
`timescale 1ns/1ps

module odt_target_decode (
    input  logic [odt_pkg::TYPE_WIDTH-1:0] cfg_type_i,
    input  logic [odt_pkg::LAT_WIDTH-1:0]  cfg_tcl_i,
    input  logic [odt_pkg::LAT_WIDTH-1:0]  cfg_cwl_i,
    input  logic [odt_pkg::AL_WIDTH-1:0]   cfg_al_i,
    input  logic [odt_pkg::BL_WIDTH-1:0]   cfg_burst_length_i,
    input  logic [odt_pkg::MAP_WIDTH-1:0]  cfg_write_odt_map_i,
    input  logic [odt_pkg::MAP_WIDTH-1:0]  cfg_read_odt_map_i,
    input  logic                           do_write_i,
    input  logic                           do_read_i,
    input  logic [odt_pkg::CHIP_COUNT-1:0] to_chip_i,     // one-hot
    odt_req_if.source                      req
);
    import odt_pkg::*;

    logic [ODT_WIDTH-1:0]     wr_map [CHIP_COUNT];   // per chip write odt pins
    logic [ODT_WIDTH-1:0]     rd_map [CHIP_COUNT];   // per chip read odt pins
    logic [ODT_WIDTH-1:0]     wr_mask;
    logic [ODT_WIDTH-1:0]     rd_mask;
    logic                     is_ddr2;
    logic                     is_ddr3;
    logic                     type_known;
    logic [LAT_SUM_WIDTH-1:0] cwl_sum;               // cwl + al
    logic [LAT_SUM_WIDTH-1:0] tcl_sum;               // tcl + al
    logic [LAT_SUM_WIDTH-1:0] wr_lat;
    logic [LAT_SUM_WIDTH-1:0] rd_lat;
    logic [BL_WIDTH-1:0]      half_bl;
    logic [BL_WIDTH-1:0]      win_sum;

    // chip c owns bits [c*ODT_WIDTH +: ODT_WIDTH] of each flattened map
    always_comb
    begin
        for (int c = 0; c < CHIP_COUNT; c++)
        begin
            wr_map[c] = cfg_write_odt_map_i[c*ODT_WIDTH +: ODT_WIDTH];
            rd_map[c] = cfg_read_odt_map_i[c*ODT_WIDTH +: ODT_WIDTH];
        end
    end

    // one-hot select, no chip selected means no pins
    always_comb
    begin
        wr_mask = '0;
        rd_mask = '0;
        for (int c = 0; c < CHIP_COUNT; c++)
        begin
            if (to_chip_i[c])
            begin
                wr_mask = wr_map[c];
                rd_mask = rd_map[c];
            end
        end
    end

    assign is_ddr2    = (cfg_type_i == MEM_TYPE_DDR2);
    assign is_ddr3    = (cfg_type_i == MEM_TYPE_DDR3);
    assign type_known = is_ddr2 | is_ddr3;        // other memories never terminate

    // strobes fan out per pin, read and write can both fire in one clock
    assign req.wr_hit = (do_write_i && type_known) ? wr_mask : '0;
    assign req.rd_hit = (do_read_i && type_known) ? rd_mask : '0;

    // latency sums, widened so al cannot overflow the add
    assign cwl_sum = LAT_SUM_WIDTH'(cfg_cwl_i) + LAT_SUM_WIDTH'(cfg_al_i);
    assign tcl_sum = LAT_SUM_WIDTH'(cfg_tcl_i) + LAT_SUM_WIDTH'(cfg_al_i);

    always_comb
    begin
        if (is_ddr2)
        begin
            wr_lat = tcl_sum - DDR2_WR_OFS;       // ddr2 write latency is rl - 1
            rd_lat = tcl_sum - DDR2_RD_OFS;
        end
        else
        begin
            wr_lat = cwl_sum - DDR3_WR_OFS;       // ddr3 uses cwl for writes
            rd_lat = tcl_sum - DDR3_RD_OFS;
        end
    end

    // valid configs keep these in 1..31
    assign req.wr_delay = wr_lat[DELAY_WIDTH-1:0];
    assign req.rd_delay = rd_lat[DELAY_WIDTH-1:0];

    // bl4 gives 4 clocks, bl8 gives 6
    assign half_bl       = cfg_burst_length_i >> 1;
    assign win_sum       = half_bl + WIN_PAD;
    assign req.win_width = win_sum[WIN_WIDTH-1:0];

endmodule

//--- src/odt_req_if.sv
// odt request bus from the target decoder to every pin timer
`timescale 1ns/1ps

interface odt_req_if;
    import odt_pkg::*;

    logic [ODT_WIDTH-1:0]   wr_hit;     // write strobe, one bit per odt pin
    logic [ODT_WIDTH-1:0]   rd_hit;     // read strobe, one bit per odt pin
    logic [DELAY_WIDTH-1:0] wr_delay;   // clocks from write strobe to window open
    logic [DELAY_WIDTH-1:0] rd_delay;   // clocks from read strobe to window open
    logic [WIN_WIDTH-1:0]   win_width;  // clocks the window stays open

    // decoder side drives everything
    modport source (
        output wr_hit,
        output rd_hit,
        output wr_delay,
        output rd_delay,
        output win_width
    );

    // pin timers only look
    modport sink (
        input wr_hit,
        input rd_hit,
        input wr_delay,
        input rd_delay,
        input win_width
    );

endinterface

//--- src/odt_pkg.sv
// odt generator package with sizes, memory type codes and latency offsets
package odt_pkg;

    // geometry
    localparam int CHIP_COUNT = 4;                      // one-hot chip selects from the arbiter
    localparam int ODT_WIDTH = 4;                       // odt pins on the afi
    localparam int MAP_WIDTH = CHIP_COUNT * ODT_WIDTH;  // flattened per-chip odt map
    localparam int PIN_SEL_WIDTH = $clog2(ODT_WIDTH);   // index of one odt pin

    // configuration field widths
    localparam int TYPE_WIDTH = 3;
    localparam int LAT_WIDTH = 4;                       // tcl and cwl
    localparam int AL_WIDTH = 3;                        // additive latency
    localparam int BL_WIDTH = 5;                        // burst length, 4 or 8 in practice

    // memory type codes, anything else gives no odt
    localparam logic [TYPE_WIDTH-1:0] MEM_TYPE_DDR2 = 3'd1;
    localparam logic [TYPE_WIDTH-1:0] MEM_TYPE_DDR3 = 3'd2;

    // timer sizes
    localparam int DELAY_DEPTH = 32;                    // stages per delay line
    localparam int DELAY_WIDTH = 5;                     // enough to index every stage
    localparam int WIN_WIDTH = 4;                       // window width and window counter

    // latency sums carry one spare bit so tcl + al cannot wrap
    localparam int LAT_SUM_WIDTH = DELAY_WIDTH + 1;

    // subtracted from the latency sums to give the delay line tap
    localparam logic [LAT_SUM_WIDTH-1:0] DDR3_WR_OFS = 6'd2;   // cwl + al - 2
    localparam logic [LAT_SUM_WIDTH-1:0] DDR3_RD_OFS = 6'd2;   // tcl + al - 2
    localparam logic [LAT_SUM_WIDTH-1:0] DDR2_WR_OFS = 6'd4;   // tcl + al - 4
    localparam logic [LAT_SUM_WIDTH-1:0] DDR2_RD_OFS = 6'd3;   // tcl + al - 3

    // window is half the burst plus two clocks of guard
    localparam logic [BL_WIDTH-1:0] WIN_PAD = 5'd2;

endpackage
